// File: Makefile
VERILATOR ?= verilator
TOP       ?= regs_tb
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
SIM_ARGS  ?= +verilator+error+limit+100
PASS_TEXT ?= TEST RESULT: PASS

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run $(TOP), check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -o V$(TOP) -f $(FILELIST)
	-./$(BUILD_DIR)/V$(TOP) $(SIM_ARGS) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "$(PASS_TEXT)" $(LOG) || { echo "Simulation failed, see $(LOG)"; exit 1; }
	@echo "Simulation passed"

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: filelist.f
source/sm83_regs_pkg.sv
source/reg_control.sv
source/gpr_file.sv
source/temp_wz.sv
source/pointer_regs.sv
source/idu.sv
source/regs_buses_top.sv
verification/tb_clock.sv
verification/regs_assertions.sv
verification/regs_tb.sv

// File: source/gpr_file.sv
`timescale 1ns/1ns

module gpr_file (
	input  logic                 clk,
	input  logic                 arst_n,
	input  sm83_regs_pkg::ctrl_t ctrl,
	input  logic [7:0]           din,
	input  sm83_regs_pkg::pair_u idu_result,
	input  sm83_regs_pkg::pair_u wz,
	output sm83_regs_pkg::regs_t regs,
	output logic [7:0]           dout,
	output logic [7:0]           a_out
);
	import sm83_regs_pkg::*;

	logic [7:0] r      [0:6]; // A, B, C, D, E, H, L
	logic [7:0] r_next [0:6];
	logic [7:0] ir;
	logic [7:0] src_byte;
	logic [7:0] byte_in;
	pair_u      pair_in;

	assign src_byte = (ctrl.src == R_Z) ? wz.bytes.lo : r[ctrl.src];
	assign byte_in  = (ctrl.wr_sel == WR_REG) ? src_byte : din;
	assign pair_in  = (ctrl.wr_sel == WR_WZ) ? wz : idu_result;

	always_comb begin
		for (int i = 0; i < 7; i++) begin
			r_next[i] = r[i];
			if (ctrl.ld_gpr[i])
				r_next[i] = byte_in;
		end
		// BC, DE, HL sit at index pairs 1/2, 3/4, 5/6
		for (int p = 0; p < 3; p++) begin
			if (ctrl.ld_pair[p]) begin
				r_next[2*p+1] = pair_in.bytes.hi;
				r_next[2*p+2] = pair_in.bytes.lo;
			end
		end
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			r    <= '{default: 8'h00};
			ir   <= 8'h00;
			dout <= 8'h00;
		end else begin
			r <= r_next;
			if (ctrl.ld_ir)
				ir <= din; // Opcode straight from the data bus
			if (ctrl.dout_en)
				dout <= src_byte;
		end
	end

	assign regs  = '{a: r[0], b: r[1], c: r[2], d: r[3], e: r[4], h: r[5], l: r[6], ir: ir};
	assign a_out = r[0];

endmodule

// File: source/idu.sv
`timescale 1ns/1ns

module idu (
	input  logic                 clk,
	input  logic                 arst_n,
	input  sm83_regs_pkg::ctrl_t ctrl,
	input  sm83_regs_pkg::regs_t regs,
	input  sm83_regs_pkg::pair_u sp,
	input  sm83_regs_pkg::pair_u pc,
	input  sm83_regs_pkg::pair_u wz,
	output sm83_regs_pkg::pair_u idu_result,
	output logic [15:0]          addr
);
	import sm83_regs_pkg::*;

	pair_u src;

	always_comb begin
		case (ctrl.idu_sel)
			P_BC:    src.word = {regs.b, regs.c};
			P_DE:    src.word = {regs.d, regs.e};
			P_HL:    src.word = {regs.h, regs.l};
			P_SP:    src = sp;
			P_PC:    src = pc;
			default: src = wz;
		endcase
	end

	always_comb begin
		case (ctrl.idu_mode)
			IDU_INC: idu_result.word = src.word + 16'd1; // Wraps at ffff
			IDU_DEC: idu_result.word = src.word - 16'd1;
			default: idu_result.word = src.word;
		endcase
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n)
			addr <= 16'h0000;
		else if (ctrl.addr_en)
			addr <= src.word; // Address before the IDU step
	end

endmodule

// File: source/pointer_regs.sv
`timescale 1ns/1ns

module pointer_regs (
	input  logic                 clk,
	input  logic                 arst_n,
	input  sm83_regs_pkg::ctrl_t ctrl,
	input  sm83_regs_pkg::pair_u idu_result,
	input  sm83_regs_pkg::pair_u wz,
	input  logic [7:0]           ir,
	output sm83_regs_pkg::pair_u sp,
	output sm83_regs_pkg::pair_u pc
);
	import sm83_regs_pkg::*;

	pair_u       pair_in;
	logic [15:0] rst_vec;

	// Jumps come in through WZ, everything else through the IDU
	assign pair_in = (ctrl.wr_sel == WR_WZ) ? wz : idu_result;
	assign rst_vec = 16'(ir[5:3]) << RST_VEC_SHIFT; // 00h, 08h .. 38h

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			sp.word <= 16'h0000;
		end else if (ctrl.ld_sp) begin
			sp <= pair_in;
		end
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			pc.word <= 16'h0000;
		end else begin
			if (ctrl.pc_clr)
				pc.word <= PC_RESET; // Synchronous clear wins
			else if (ctrl.pc_vec)
				pc.word <= rst_vec;
			else if (ctrl.ld_pc)
				pc <= pair_in;
		end
	end

endmodule

// File: source/reg_control.sv
`timescale 1ns/1ns

module reg_control (
	input  logic                 clk,
	input  logic                 arst_n,
	input  logic                 cmd_valid,
	input  sm83_regs_pkg::cmd_t  cmd,
	output sm83_regs_pkg::ctrl_t ctrl,
	output logic                 out_valid,
	output logic                 illegal
);
	import sm83_regs_pkg::*;

	logic legal;

	// Route a pair write to its destination registers
	function automatic ctrl_t pair_dst(input ctrl_t c, input pair_e p, input logic wz_ok);
		ctrl_t r;
		r = c;
		case (p)
			P_BC: r.ld_pair[0] = 1'b1;
			P_DE: r.ld_pair[1] = 1'b1;
			P_HL: r.ld_pair[2] = 1'b1;
			P_SP: r.ld_sp = 1'b1;
			P_PC: r.ld_pc = 1'b1;
			default: begin
				r.ld_w = wz_ok; // WZ onto itself is a no-op
				r.ld_z = wz_ok;
			end
		endcase
		return r;
	endfunction

	always_comb begin
		ctrl  = '0;
		legal = 1'b1;
		if (cmd_valid) begin
			ctrl.src     = cmd.src;
			ctrl.idu_sel = cmd.pair;
			ctrl.addr_en = 1'b1;
			case (cmd.op)
				OP_NOP: ctrl.addr_en = 1'b0;
				OP_LD_R_DIN: begin
					ctrl.wr_sel = WR_DIN;
					if (cmd.dst == R_Z)
						ctrl.ld_z = 1'b1;
					else
						ctrl.ld_gpr[cmd.dst] = 1'b1;
				end
				OP_LD_R_R: begin
					ctrl.wr_sel = WR_REG;
					if (cmd.dst == R_Z)
						legal = 1'b0; // Z is not a byte copy target
					else
						ctrl.ld_gpr[cmd.dst] = 1'b1;
				end
				OP_LD_IR: begin
					ctrl.ld_ir    = 1'b1;
					ctrl.wr_sel   = WR_IDU;
					ctrl.idu_sel  = P_PC; // Fetch address, then PC + 1
					ctrl.idu_mode = IDU_INC;
					ctrl.ld_pc    = 1'b1;
				end
				OP_LD_WZ_DIN: begin
					ctrl.wr_sel = WR_DIN;
					ctrl.ld_w   = (cmd.dst == R_H);
					ctrl.ld_z   = (cmd.dst != R_H);
				end
				OP_LD_PAIR_WZ: begin
					ctrl.wr_sel = WR_WZ;
					ctrl        = pair_dst(ctrl, cmd.pair, 1'b0);
				end
				OP_INC_PAIR, OP_DEC_PAIR: begin
					ctrl.wr_sel   = WR_IDU;
					ctrl.idu_mode = (cmd.op == OP_INC_PAIR) ? IDU_INC : IDU_DEC;
					ctrl          = pair_dst(ctrl, cmd.pair, 1'b1);
				end
				OP_ADDR_PAIR: ctrl.idu_mode = IDU_PASS;
				OP_STORE_R:   ctrl.dout_en = 1'b1;
				OP_RST:       ctrl.pc_vec = 1'b1;
				OP_SYNC_RST:  ctrl.pc_clr = 1'b1;
				default:      legal = 1'b0;
			endcase
			if (cmd.pair > P_WZ && cmd.op inside {OP_LD_PAIR_WZ, OP_INC_PAIR,
					OP_DEC_PAIR, OP_ADDR_PAIR})
				legal = 1'b0; // Pair code 6 or 7
			if (!legal)
				ctrl = '0; // Rejected command touches nothing
		end
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			out_valid <= 1'b0;
			illegal   <= 1'b0;
		end else begin
			out_valid <= cmd_valid;
			illegal   <= illegal | (cmd_valid & ~legal); // Sticky
		end
	end

endmodule

// File: source/regs_buses_top.sv
`timescale 1ns/1ns

module regs_buses_top (
	input  logic                clk,
	input  logic                arst_n,
	input  logic                cmd_valid,
	input  sm83_regs_pkg::cmd_t cmd,
	input  logic [7:0]          din,
	output logic [15:0]         addr,
	output logic [7:0]          dout,
	output logic [7:0]          a_out,
	output logic                out_valid,
	output logic                illegal
);
	import sm83_regs_pkg::*;

	ctrl_t ctrl;
	regs_t regs;
	pair_u wz;
	pair_u sp;
	pair_u pc;
	pair_u idu_result;

	reg_control u_control (
		.clk       (clk),
		.arst_n    (arst_n),
		.cmd_valid (cmd_valid),
		.cmd       (cmd),
		.ctrl      (ctrl),
		.out_valid (out_valid),
		.illegal   (illegal)
	);

	gpr_file u_gpr (
		.clk        (clk),
		.arst_n     (arst_n),
		.ctrl       (ctrl),
		.din        (din),
		.idu_result (idu_result),
		.wz         (wz),
		.regs       (regs),
		.dout       (dout),
		.a_out      (a_out)
	);

	temp_wz u_wz (
		.clk        (clk),
		.arst_n     (arst_n),
		.ctrl       (ctrl),
		.din        (din),
		.idu_result (idu_result),
		.wz         (wz)
	);

	pointer_regs u_ptr (
		.clk        (clk),
		.arst_n     (arst_n),
		.ctrl       (ctrl),
		.idu_result (idu_result),
		.wz         (wz),
		.ir         (regs.ir), // RST vector bits
		.sp         (sp),
		.pc         (pc)
	);

	idu u_idu (
		.clk        (clk),
		.arst_n     (arst_n),
		.ctrl       (ctrl),
		.regs       (regs),
		.sp         (sp),
		.pc         (pc),
		.wz         (wz),
		.idu_result (idu_result),
		.addr       (addr)
	);

endmodule

// File: source/sm83_regs_pkg.sv
package sm83_regs_pkg;

	localparam int          RST_VEC_SHIFT = 3;        // RST n jumps to n * 8
	localparam logic [15:0] PC_RESET      = 16'h0000; // PC after SYNC_RST

	typedef enum logic [2:0] {
		R_A, R_B, R_C, R_D, R_E, R_H, R_L, R_Z
	} reg8_e;

	typedef enum logic [2:0] {
		P_BC, P_DE, P_HL, P_SP, P_PC, P_WZ
	} pair_e;

	typedef enum logic [3:0] {
		OP_NOP,
		OP_LD_R_DIN,
		OP_LD_R_R,
		OP_LD_IR,
		OP_LD_WZ_DIN,
		OP_LD_PAIR_WZ,
		OP_INC_PAIR,
		OP_DEC_PAIR,
		OP_ADDR_PAIR,
		OP_STORE_R,
		OP_RST,
		OP_SYNC_RST
	} op_e;

	// Where a register write takes its data from
	typedef enum logic [1:0] {
		WR_DIN, WR_REG, WR_IDU, WR_WZ
	} wr_sel_e;

	typedef enum logic [1:0] {
		IDU_PASS, IDU_INC, IDU_DEC
	} idu_mode_e;

	typedef struct packed {
		op_e        op;
		reg8_e      dst;
		reg8_e      src;
		pair_e      pair;
		logic [7:0] din;
	} cmd_t;

	typedef struct packed {
		logic [7:0] hi;
		logic [7:0] lo;
	} bytes_t;

	typedef union packed {
		logic [15:0] word; // IDU and address view
		bytes_t      bytes; // Byte register view
	} pair_u;

	typedef struct packed {
		logic [6:0] ld_gpr;  // Indexed by reg8_e, A..L
		logic       ld_ir;
		logic       ld_w;
		logic       ld_z;
		logic       ld_sp;
		logic       ld_pc;
		logic [2:0] ld_pair; // HL, DE, BC
		wr_sel_e    wr_sel;
		reg8_e      src;
		pair_e      idu_sel;
		idu_mode_e  idu_mode;
		logic       addr_en;
		logic       dout_en;
		logic       pc_vec;  // RST vector load
		logic       pc_clr;  // SYNC_RST
	} ctrl_t;

	typedef struct packed {
		logic [7:0] a;
		logic [7:0] b;
		logic [7:0] c;
		logic [7:0] d;
		logic [7:0] e;
		logic [7:0] h;
		logic [7:0] l;
		logic [7:0] ir;
	} regs_t;

endpackage

// File: source/temp_wz.sv
`timescale 1ns/1ns

module temp_wz (
	input  logic                 clk,
	input  logic                 arst_n,
	input  sm83_regs_pkg::ctrl_t ctrl,
	input  logic [7:0]           din,
	input  sm83_regs_pkg::pair_u idu_result,
	output sm83_regs_pkg::pair_u wz
);
	import sm83_regs_pkg::*;

	logic [7:0] w_in;
	logic [7:0] z_in;
	logic       from_idu;

	// Same choice as the silicon: IDU result or data bus
	assign from_idu = (ctrl.wr_sel == WR_IDU);
	assign z_in     = from_idu ? idu_result.bytes.lo : din;
	assign w_in     = from_idu ? idu_result.bytes.hi : din;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			wz.word <= 16'h0000;
		end else begin
			if (ctrl.ld_w)
				wz.bytes.hi <= w_in;
			if (ctrl.ld_z)
				wz.bytes.lo <= z_in;
		end
	end

endmodule

// File: verification/regs_assertions.sv
`timescale 1ns/1ns

module regs_assertions (
	input logic                 clk,
	input logic                 arst_n,
	input logic                 cmd_valid,
	input sm83_regs_pkg::ctrl_t ctrl,
	input logic                 out_valid
);
	int         fail_count = 0; // Read by the testbench
	logic [4:0] pair_loads;

	assign pair_loads = {ctrl.ld_pair, ctrl.ld_sp, ctrl.ld_pc}; // HL DE BC SP PC

	reset_quiet: assert property (@(posedge clk) !arst_n |-> !out_valid)
		else begin
			fail_count++;
			$error("out_valid is high while reset is held");
		end

	valid_rise: assert property (@(posedge clk) disable iff (!arst_n) cmd_valid |=> out_valid)
		else begin
			fail_count++;
			$error("out_valid did not follow an accepted command");
		end

	valid_fall: assert property (@(posedge clk) disable iff (!arst_n) !cmd_valid |=> !out_valid)
		else begin
			fail_count++;
			$error("out_valid rose without a command");
		end

	one_pair_dst: assert property (@(posedge clk) disable iff (!arst_n) $onehot0(pair_loads))
		else begin
			fail_count++;
			$error("More than one pair destination enabled");
		end

endmodule

bind reg_control regs_assertions u_assert (
	.clk       (clk),
	.arst_n    (arst_n),
	.cmd_valid (cmd_valid),
	.ctrl      (ctrl),
	.out_valid (out_valid)
);

// File: verification/regs_patterns.txt
# op dst src pair din mask addr dout a_out illegal name (all fields hex)
# mask bits: 1=addr 2=dout 4=a_out 8=illegal
3 0 0 4 3e d 0000 00 00 0 fetch_0
3 0 0 4 00 1 0001 00 00 0 fetch_1
3 0 0 4 d7 1 0002 00 00 0 fetch_2
a 0 0 4 00 1 0003 00 00 0 rst_10
8 0 0 4 00 1 0010 00 00 0 addr_pc_10
b 0 0 4 00 1 0010 00 00 0 sync_rst
8 0 0 4 00 1 0000 00 00 0 addr_pc_0
1 0 0 0 5a 4 0000 00 5a 0 ld_a
1 1 0 0 81 4 0000 00 5a 0 ld_b
1 2 0 0 c3 4 0000 00 5a 0 ld_c
2 3 1 0 00 4 0000 00 5a 0 mov_d_b
9 0 3 0 00 6 0000 81 5a 0 st_d
2 0 2 0 00 4 0000 00 c3 0 mov_a_c
9 0 0 0 00 6 0000 c3 c3 0 st_a
1 7 0 0 44 8 0000 00 00 0 ld_z_din
2 4 7 0 00 0 0000 00 00 0 mov_e_z
9 0 4 0 00 2 0000 44 00 0 st_e
4 0 0 0 34 0 0000 00 00 0 ld_z_34
4 5 0 0 12 0 0000 00 00 0 ld_w_12
5 0 0 0 00 0 0000 00 00 0 wz_to_bc
8 0 0 0 00 1 1234 00 00 0 addr_bc
9 0 1 0 00 2 0000 12 00 0 st_b_hi
4 5 0 0 ab 0 0000 00 00 0 ld_w_ab
5 0 0 1 00 0 0000 00 00 0 wz_to_de
8 0 0 1 00 1 ab34 00 00 0 addr_de
4 0 0 0 ff 0 0000 00 00 0 ld_z_ff
5 0 0 2 00 0 0000 00 00 0 wz_to_hl
8 0 0 2 00 1 abff 00 00 0 addr_hl
4 5 0 0 ff 0 0000 00 00 0 ld_w_ff
5 0 0 3 00 0 0000 00 00 0 wz_to_sp
8 0 0 3 00 1 ffff 00 00 0 addr_sp
6 0 0 3 00 1 ffff 00 00 0 inc_sp_wrap
7 0 0 3 00 1 0000 00 00 0 dec_sp_wrap
8 0 0 3 00 1 ffff 00 00 0 addr_sp_ff
6 0 0 2 00 1 abff 00 00 0 inc_hl
8 0 0 2 00 1 ac00 00 00 0 addr_hl_inc
9 0 5 0 00 2 0000 ac 00 0 st_h
9 0 6 0 00 2 0000 00 00 0 st_l
7 0 0 0 00 1 1234 00 00 0 dec_bc
8 0 0 0 00 1 1233 00 00 0 addr_bc_dec
6 0 0 5 00 1 ffff 00 00 0 inc_wz_wrap
8 0 0 5 00 1 0000 00 00 0 addr_wz
e 0 0 0 77 f 0000 00 c3 1 bad_op
8 0 0 6 00 9 0000 00 00 1 bad_pair
2 7 0 0 00 f 0000 00 c3 1 bad_dst_z
9 0 1 0 00 6 0000 12 c3 1 st_b_kept
8 0 0 2 00 9 ac00 00 00 1 addr_hl_kept
8 0 0 4 00 9 0000 00 00 1 addr_pc_kept

// File: verification/regs_tb.sv
`timescale 1ns/1ns

module regs_tb;
	import sm83_regs_pkg::*;

	localparam time DRIVE_DELAY  = 10; // After the rising edge
	localparam int  RESET_CYCLES = 8;
	localparam int  WAIT_LIMIT   = 4;

	logic        clk;
	logic        arst_n;
	logic        cmd_valid;
	cmd_t        cmd;
	logic [7:0]  din;
	logic [15:0] addr;
	logic [7:0]  dout;
	logic [7:0]  a_out;
	logic        out_valid;
	logic        illegal;

	logic [31:0] lfsr;
	int          lines_run;

	tb_clock u_clk (
		.clk (clk)
	);

	regs_buses_top u_dut (
		.clk       (clk),
		.arst_n    (arst_n),
		.cmd_valid (cmd_valid),
		.cmd       (cmd),
		.din       (din),
		.addr      (addr),
		.dout      (dout),
		.a_out     (a_out),
		.out_valid (out_valid),
		.illegal   (illegal)
	);

	// Fibonacci form, taps 32 22 2 1
	function automatic logic [31:0] next_lfsr(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	function automatic string to_name(input logic [8*16-1:0] v);
		string s;
		s = "";
		for (int i = 15; i >= 0; i--)
			if (v[8*i +: 8] != 8'h00)
				s = $sformatf("%s%c", s, v[8*i +: 8]);
		return s;
	endfunction

	task automatic fail_now(input string msg);
		$display("%s", msg);
		$display("TEST RESULT: FAIL");
		$fatal(1, "Simulation stopped at the first error");
	endtask

	task automatic check_byte(input string name, input logic [7:0] exp, input logic [7:0] act);
		if (act !== exp)
			fail_now($sformatf("ERROR %s: expected %02h, actual %02h", name, exp, act));
	endtask

	task automatic check_word(input string name, input pair_u exp, input pair_u act);
		if (act.word !== exp.word)
			fail_now($sformatf("ERROR %s: expected %04h, actual %04h", name, exp.word, act.word));
	endtask

	task automatic check_flag(input string name, input logic exp, input logic act);
		if (act !== exp)
			fail_now($sformatf("ERROR %s: expected %0b, actual %0b", name, exp, act));
	endtask

	task automatic apply_cmd(input logic [3:0] op, input logic [2:0] dst, input logic [2:0] src,
			input logic [2:0] pair, input logic [7:0] data);
		cmd.op    = op_e'(op);
		cmd.dst   = reg8_e'(dst);
		cmd.src   = reg8_e'(src);
		cmd.pair  = pair_e'(pair); // Codes 6 and 7 pass through on purpose
		cmd.din   = data;
		din       = data;
		cmd_valid = 1'b1;
	endtask

	task automatic wait_output(input string name);
		int waited;
		waited = 0;
		while (!out_valid) begin
			if (waited == WAIT_LIMIT)
				fail_now($sformatf("Timeout: out_valid never rose for step %s", name));
			@(posedge clk);
			#DRIVE_DELAY;
			waited++;
		end
	endtask

	// Two LFSR bits give 0 to 3 idle cycles
	task automatic random_idles(output int n);
		n = 0;
		for (int i = 0; i < 2; i++) begin
			lfsr = next_lfsr(lfsr);
			n    = (n << 1) | int'(lfsr[0]);
		end
	endtask

	initial begin
		int               fd;
		int               n;
		int               idles;
		logic [8*128-1:0] line_buf;
		logic [8*16-1:0]  name_v;
		logic [31:0]      f_op, f_dst, f_src, f_pair, f_din;
		logic [31:0]      f_mask, f_addr, f_dout, f_a, f_ill;
		string            name;
		pair_u            exp_addr;
		pair_u            act_addr;

		lines_run = 0;
		lfsr      = 32'hc7e4;
		arst_n    = 1'b0;
		cmd_valid = 1'b0;
		cmd       = '0;
		din       = 8'h00;

		fd = $fopen("verification/regs_patterns.txt", "r");
		if (fd == 0)
			fail_now("Could not open the pattern file verification/regs_patterns.txt");

		repeat (RESET_CYCLES) @(posedge clk);
		#DRIVE_DELAY;
		arst_n = 1'b1;
		check_flag("reset out_valid", 1'b0, out_valid);
		check_flag("reset illegal", 1'b0, illegal);
		check_byte("reset a_out", 8'h00, a_out);

		while ($fgets(line_buf, fd) != 0) begin
			name_v = '0;
			n = $sscanf(line_buf, "%h %h %h %h %h %h %h %h %h %h %s", f_op, f_dst, f_src,
				f_pair, f_din, f_mask, f_addr, f_dout, f_a, f_ill, name_v);
			if (n == 11) begin
				name = to_name(name_v);
				apply_cmd(f_op[3:0], f_dst[2:0], f_src[2:0], f_pair[2:0], f_din[7:0]);
				@(posedge clk);
				#DRIVE_DELAY;
				cmd_valid = 1'b0;
				wait_output(name);
				if (f_mask[0]) begin
					exp_addr.word = f_addr[15:0];
					act_addr.word = addr;
					check_word({name, " addr"}, exp_addr, act_addr);
				end
				if (f_mask[1])
					check_byte({name, " dout"}, f_dout[7:0], dout);
				if (f_mask[2])
					check_byte({name, " a_out"}, f_a[7:0], a_out);
				if (f_mask[3])
					check_flag({name, " illegal"}, f_ill[0], illegal);
				if (u_dut.u_control.u_assert.fail_count != 0)
					fail_now($sformatf("A bound assertion failed during step %s", name));
				lines_run++;
				random_idles(idles);
				repeat (idles) begin
					@(posedge clk);
					#DRIVE_DELAY;
				end
			end else if (n > 0) begin
				fail_now("A line of the pattern file has the wrong number of fields");
			end
		end
		$fclose(fd);

		if (lines_run == 0)
			fail_now("The pattern file held no command lines");
		if (u_dut.u_control.u_assert.fail_count == 0) begin
			$display("TEST RESULT: PASS");
			$finish;
		end else begin
			$display("A bound assertion failed after the last step");
			$display("TEST RESULT: FAIL");
			$fatal(1, "Simulation ended with errors");
		end
	end

endmodule

// File: verification/tb_clock.sv
`timescale 1ns/1ns

module tb_clock (
	output logic clk
);
	localparam time HALF_PERIOD = 50; // 100 ns period

	initial begin
		clk = 1'b0;
		forever #HALF_PERIOD clk = ~clk;
	end

endmodule
